// File: design/mat_pkg.sv
`default_nettype none

package mat_pkg;

    localparam int DIM_W  = 4;  // one dimension, 1..15
    localparam int ADDR_W = 9;  // matrix memory word address
    localparam int CNT_W  = 2;  // stored copies per shape, saturates at 2

    typedef struct packed {
        logic [DIM_W-1:0] m;
        logic [DIM_W-1:0] n;
    } shape_t;

    typedef enum logic [2:0] {
        OP_TRANSPOSE = 3'd0,
        OP_ADD       = 3'd1,
        OP_SCALE     = 3'd2,
        OP_MATMUL    = 3'd3
    } op_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        shape_t            shape;
    } operand_t;

    // command word for the arithmetic core
    typedef struct packed {
        op_t              op;
        operand_t         op1;
        operand_t         op2;
        operand_t         res;
        logic [DIM_W-1:0] scalar;
    } calc_cmd_t;

    typedef enum logic [1:0] {
        TASK_STORE = 2'd0,  // full matrix for storage
        TASK_QUERY = 2'd1,  // shape only
        TASK_INDEX = 2'd2   // operand index
    } input_task_t;

    // ledger answer for one query shape
    typedef struct packed {
        logic              found;
        logic [CNT_W-1:0]  count;
        logic [ADDR_W-1:0] start;
        logic [ADDR_W-1:0] wr_addr;
    } lut_hit_t;

endpackage

`default_nettype wire

// File: design/btn_edge.sv
`default_nettype none

module btn_edge #(
    parameter int DEBOUNCE_CYCLES = 250000
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  i_btn,
    output logic o_press
);

    localparam int CTR_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [1:0]       sync;
    logic [CTR_W-1:0] stable_cnt;
    logic             level;  // filtered button level

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync       <= 2'b00;
            stable_cnt <= '0;
            level      <= 1'b0;
            o_press    <= 1'b0;
        end else begin
            sync    <= {sync[0], i_btn};
            o_press <= 1'b0;
            if (sync[1] == level) begin
                stable_cnt <= '0;  // bounce, start over
            end else if (stable_cnt == CTR_W'(DEBOUNCE_CYCLES - 1)) begin
                stable_cnt <= '0;
                level      <= sync[1];
                o_press    <= sync[1];  // rising edge of filtered level
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/shape_ledger.sv
`default_nettype none

module shape_ledger #(
    parameter int MAX_TYPES = 25
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire mat_pkg::shape_t i_query,
    output mat_pkg::lut_hit_t    o_hit,
    input  wire                  i_alloc,
    input  wire                  i_rollback,
    input  wire                  i_commit,
    output logic [4:0]           o_types_count,
    output logic [7:0]           o_total_count
);

    import mat_pkg::*;

    localparam int IDX_W = $clog2(MAX_TYPES);

    shape_t            tbl_shape [MAX_TYPES];
    logic [ADDR_W-1:0] tbl_start [MAX_TYPES];
    logic              tbl_tog   [MAX_TYPES];  // which half gets the next write
    logic [CNT_W-1:0]  tbl_cnt   [MAX_TYPES];
    logic [ADDR_W-1:0] free_ptr;

    logic              hit;
    logic [IDX_W-1:0]  hit_idx;
    logic [ADDR_W-1:0] size;
    logic              do_alloc;
    logic              full;

    // undo record of the last allocation
    logic              bk_valid;
    logic              bk_new;
    logic [IDX_W-1:0]  bk_idx;
    logic [CNT_W-1:0]  bk_cnt;
    logic [ADDR_W-1:0] bk_ptr;

    assign size     = ADDR_W'(i_query.m) * ADDR_W'(i_query.n);
    assign do_alloc = i_alloc | i_commit;  // commit allocates the result shape
    assign full     = (o_types_count == 5'(MAX_TYPES));

    // ============================================================
    // lookup
    // ============================================================
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < MAX_TYPES; i++) begin
            if (i < int'(o_types_count) && tbl_shape[i] == i_query) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        o_hit.found = hit;
        o_hit.count = tbl_cnt[hit_idx];
        o_hit.start = tbl_start[hit_idx];
        if (!hit)
            o_hit.wr_addr = free_ptr;
        else if (tbl_tog[hit_idx])
            o_hit.wr_addr = tbl_start[hit_idx] + size;
        else
            o_hit.wr_addr = tbl_start[hit_idx];
    end

    // ============================================================
    // allocation and rollback
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_types_count <= '0;
            free_ptr      <= '0;
            bk_valid      <= 1'b0;
            for (int i = 0; i < MAX_TYPES; i++)
                tbl_cnt[i] <= '0;
        end else if (do_alloc) begin
            bk_valid <= hit || !full;
            if (hit) begin
                if (tbl_cnt[hit_idx] != CNT_W'(2))
                    tbl_cnt[hit_idx] <= tbl_cnt[hit_idx] + 1'b1;
            end else if (!full) begin
                tbl_cnt[o_types_count] <= CNT_W'(1);
                free_ptr               <= free_ptr + (size << 1);  // two slots per type
                o_types_count          <= o_types_count + 1'b1;
            end
        end else if (i_rollback && bk_valid) begin
            bk_valid <= 1'b0;
            if (bk_new) begin
                o_types_count <= o_types_count - 1'b1;
                free_ptr      <= bk_ptr;
            end else begin
                tbl_cnt[bk_idx] <= bk_cnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            bk_new <= !hit;
            bk_idx <= hit_idx;
            bk_cnt <= tbl_cnt[hit_idx];
            bk_ptr <= free_ptr;
            if (hit) begin
                tbl_tog[hit_idx] <= ~tbl_tog[hit_idx];
            end else if (!full) begin
                tbl_shape[o_types_count] <= i_query;
                tbl_start[o_types_count] <= free_ptr;
                tbl_tog[o_types_count]   <= 1'b1;
            end
        end else if (i_rollback && bk_valid && !bk_new) begin
            tbl_tog[bk_idx] <= ~tbl_tog[bk_idx];
        end
    end

    always_comb begin
        o_total_count = '0;
        for (int i = 0; i < MAX_TYPES; i++) begin
            if (i < int'(o_types_count))
                o_total_count = o_total_count + 8'(tbl_cnt[i]);
        end
    end

endmodule

`default_nettype wire

// File: design/calc_sequencer.sv
`default_nettype none

module calc_sequencer (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          i_confirm,
    input  wire                          i_retry,
    input  wire                          i_menu,
    input  wire [7:0]                    i_sw,
    input  wire                          i_dims_valid,
    input  wire mat_pkg::shape_t         i_dim,
    input  wire                          i_rx_done,
    input  wire                          i_error_flag,
    input  wire [mat_pkg::CNT_W-1:0]     i_id,
    input  wire                          i_id_valid,
    input  wire                          i_calc_done,
    input  wire mat_pkg::lut_hit_t       i_hit,
    output mat_pkg::shape_t              o_query,
    output logic                         o_alloc,
    output logic                         o_rollback,
    output logic                         o_commit,
    output logic                         o_en_input,
    output mat_pkg::input_task_t         o_input_task,
    output logic                         o_addr_ready,
    output logic [mat_pkg::ADDR_W-1:0]   o_base_addr,
    output logic                         o_start_calc,
    output mat_pkg::calc_cmd_t           o_calc_cmd,
    output logic                         o_logic_error,
    output logic [7:0]                   o_led
);

    import mat_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE, S_INPUT, S_SEL_OP, S_GET_DIM, S_GET_ID,
        S_GET_SCALAR, S_CHECK, S_EXEC, S_BUSY, S_WAIT
    } state_t;

    state_t            state;
    state_t            last_mode;   // target of retry
    logic              stage;       // 0 first operand, 1 second
    logic              alloc_busy;
    shape_t            dim_q;
    logic [ADDR_W-1:0] cur_start;
    logic [CNT_W-1:0]  cur_cnt;
    logic [ADDR_W-1:0] cur_size;
    operand_t          pick;
    shape_t            res_shape;
    logic              legal;

    // ============================================================
    // operand address, result shape, legality
    // ============================================================
    assign cur_size = ADDR_W'(dim_q.m) * ADDR_W'(dim_q.n);

    always_comb begin
        pick.shape = dim_q;
        pick.addr  = cur_start + ADDR_W'(i_id - 1'b1) * cur_size;
    end

    always_comb begin
        case (o_calc_cmd.op)
            OP_TRANSPOSE: res_shape = '{m: o_calc_cmd.op1.shape.n, n: o_calc_cmd.op1.shape.m};
            OP_MATMUL:    res_shape = '{m: o_calc_cmd.op1.shape.m, n: o_calc_cmd.op2.shape.n};
            default:      res_shape = o_calc_cmd.op1.shape;
        endcase
    end

    always_comb begin
        case (o_calc_cmd.op)
            OP_ADD:    legal = (o_calc_cmd.op1.shape == o_calc_cmd.op2.shape);
            OP_MATMUL: legal = (o_calc_cmd.op1.shape.n == o_calc_cmd.op2.shape.m);
            default:   legal = 1'b1;
        endcase
    end

    // alloc strobe lags i_dims_valid by one cycle, so hold the shape
    always_comb begin
        if (o_alloc)
            o_query = dim_q;
        else if (state == S_INPUT || state == S_GET_DIM)
            o_query = i_dim;
        else
            o_query = res_shape;
    end

    // ============================================================
    // mode FSM
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            last_mode     <= S_INPUT;
            stage         <= 1'b0;
            alloc_busy    <= 1'b0;
            dim_q         <= '0;
            cur_start     <= '0;
            cur_cnt       <= '0;
            o_alloc       <= 1'b0;
            o_rollback    <= 1'b0;
            o_commit      <= 1'b0;
            o_en_input    <= 1'b0;
            o_input_task  <= TASK_STORE;
            o_addr_ready  <= 1'b0;
            o_base_addr   <= '0;
            o_start_calc  <= 1'b0;
            o_calc_cmd    <= '0;
            o_logic_error <= 1'b0;
            o_led         <= 8'h01;
        end else begin
            o_alloc      <= 1'b0;
            o_rollback   <= 1'b0;
            o_commit     <= 1'b0;
            o_addr_ready <= 1'b0;
            o_start_calc <= 1'b0;
            if (state != S_IDLE && i_menu) begin
                state <= S_IDLE;
            end else begin
                case (state)
                    S_IDLE: begin
                        o_en_input    <= 1'b0;
                        o_logic_error <= 1'b0;
                        o_led         <= 8'h01;
                        alloc_busy    <= 1'b0;
                        if (i_confirm && i_sw[1:0] == 2'b00) begin
                            state        <= S_INPUT;
                            last_mode    <= S_INPUT;
                            o_en_input   <= 1'b1;
                            o_input_task <= TASK_STORE;
                            o_led        <= 8'h02;
                        end else if (i_confirm && i_sw[1:0] == 2'b10) begin
                            state     <= S_SEL_OP;
                            last_mode <= S_SEL_OP;
                            o_led     <= 8'h08;
                        end
                    end

                    S_INPUT: begin
                        if (i_rx_done) begin
                            state      <= S_WAIT;
                            o_en_input <= 1'b0;
                            alloc_busy <= 1'b0;
                            o_led      <= 8'h80;
                        end else if (i_error_flag) begin
                            o_led <= 8'hFF;
                            if (alloc_busy) begin
                                o_rollback <= 1'b1;  // give the slot back
                                alloc_busy <= 1'b0;
                            end
                        end else if (i_dims_valid && !alloc_busy) begin
                            dim_q        <= i_dim;
                            o_base_addr  <= i_hit.wr_addr;
                            o_addr_ready <= 1'b1;
                            o_alloc      <= 1'b1;
                            alloc_busy   <= 1'b1;
                            o_led        <= 8'h02;
                        end
                    end

                    S_SEL_OP: begin
                        if (i_confirm && !i_sw[7]) begin  // codes 4..7 not ops
                            o_calc_cmd.op     <= op_t'(i_sw[7:5]);
                            o_calc_cmd.op2    <= '0;
                            o_calc_cmd.scalar <= '0;
                            stage             <= 1'b0;
                            o_logic_error     <= 1'b0;
                            o_en_input        <= 1'b1;
                            o_input_task      <= TASK_QUERY;
                            state             <= S_GET_DIM;
                        end
                    end

                    S_GET_DIM: begin
                        if (i_dims_valid) begin
                            if (i_hit.found && i_hit.count != '0) begin
                                dim_q        <= i_dim;
                                cur_start    <= i_hit.start;
                                cur_cnt      <= i_hit.count;
                                o_input_task <= TASK_INDEX;
                                state        <= S_GET_ID;
                            end else begin
                                o_logic_error <= 1'b1;  // shape not stored
                                o_led         <= 8'hFF;
                            end
                        end
                    end

                    S_GET_ID: begin
                        if (i_id_valid && i_id != '0 && i_id <= cur_cnt) begin
                            o_logic_error <= 1'b0;
                            o_led         <= 8'h08;
                            if (!stage)
                                o_calc_cmd.op1 <= pick;
                            else
                                o_calc_cmd.op2 <= pick;
                            if (!stage && (o_calc_cmd.op == OP_ADD
                                           || o_calc_cmd.op == OP_MATMUL)) begin
                                stage        <= 1'b1;
                                o_input_task <= TASK_QUERY;
                                state        <= S_GET_DIM;
                            end else begin
                                o_en_input <= 1'b0;
                                state      <= (o_calc_cmd.op == OP_SCALE) ? S_GET_SCALAR
                                                                          : S_CHECK;
                            end
                        end else if (i_id_valid) begin
                            o_logic_error <= 1'b1;
                            o_led         <= 8'hFF;
                        end
                    end

                    S_GET_SCALAR: begin
                        o_led <= {4'h0, i_sw[7:4]};
                        if (i_confirm) begin
                            o_calc_cmd.scalar <= i_sw[7:4];
                            state             <= S_CHECK;
                        end
                    end

                    S_CHECK: begin
                        if (legal) begin
                            state <= S_EXEC;
                        end else begin
                            o_logic_error <= 1'b1;
                            o_led         <= 8'hFF;
                            stage         <= 1'b0;
                            o_en_input    <= 1'b1;
                            o_input_task  <= TASK_QUERY;
                            state         <= S_GET_DIM;
                        end
                    end

                    S_EXEC: begin
                        o_calc_cmd.res <= '{addr: i_hit.wr_addr, shape: res_shape};
                        o_start_calc   <= 1'b1;
                        state          <= S_BUSY;
                    end

                    S_BUSY: begin
                        if (i_calc_done) begin
                            o_commit <= 1'b1;  // ledger takes the result
                            o_led    <= 8'h80;
                            state    <= S_WAIT;
                        end
                    end

                    S_WAIT: begin
                        if (i_confirm) begin
                            state <= S_IDLE;
                        end else if (i_retry) begin
                            state <= last_mode;
                            if (last_mode == S_INPUT) begin
                                o_en_input   <= 1'b1;
                                o_input_task <= TASK_STORE;
                                o_led        <= 8'h02;
                            end else begin
                                o_led <= 8'h08;
                            end
                        end
                    end

                    default: state <= S_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: design/matrix_ctrl.sv
`default_nettype none

module matrix_ctrl #(
    parameter int MAX_TYPES       = 25,
    parameter int DEBOUNCE_CYCLES = 250000
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire [2:0]                    i_btn,   // confirm, retry, menu
    input  wire [7:0]                    i_sw,
    input  wire                          i_dims_valid,
    input  wire mat_pkg::shape_t         i_dim,
    input  wire                          i_rx_done,
    input  wire                          i_error_flag,
    input  wire [mat_pkg::CNT_W-1:0]     i_id,
    input  wire                          i_id_valid,
    input  wire                          i_calc_done,
    output logic                         o_en_input,
    output mat_pkg::input_task_t         o_input_task,
    output logic                         o_addr_ready,
    output logic [mat_pkg::ADDR_W-1:0]   o_base_addr,
    output logic                         o_start_calc,
    output mat_pkg::calc_cmd_t           o_calc_cmd,
    output logic                         o_logic_error,
    output logic [7:0]                   o_led,
    output logic [4:0]                   o_types_count,
    output logic [7:0]                   o_total_count
);

    import mat_pkg::*;

    logic [2:0] press;
    shape_t     query;
    lut_hit_t   hit;
    logic       alloc;
    logic       rollback;
    logic       commit;

    for (genvar b = 0; b < 3; b++) begin : g_btn
        btn_edge #(
            .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
        ) u_btn (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_btn   (i_btn[b]),
            .o_press (press[b])
        );
    end

    shape_ledger #(
        .MAX_TYPES(MAX_TYPES)
    ) u_ledger (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_query       (query),
        .o_hit         (hit),
        .i_alloc       (alloc),
        .i_rollback    (rollback),
        .i_commit      (commit),
        .o_types_count (o_types_count),
        .o_total_count (o_total_count)
    );

    calc_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_confirm     (press[0]),
        .i_retry       (press[1]),
        .i_menu        (press[2]),
        .i_sw          (i_sw),
        .i_dims_valid  (i_dims_valid),
        .i_dim         (i_dim),
        .i_rx_done     (i_rx_done),
        .i_error_flag  (i_error_flag),
        .i_id          (i_id),
        .i_id_valid    (i_id_valid),
        .i_calc_done   (i_calc_done),
        .i_hit         (hit),
        .o_query       (query),
        .o_alloc       (alloc),
        .o_rollback    (rollback),
        .o_commit      (commit),
        .o_en_input    (o_en_input),
        .o_input_task  (o_input_task),
        .o_addr_ready  (o_addr_ready),
        .o_base_addr   (o_base_addr),
        .o_start_calc  (o_start_calc),
        .o_calc_cmd    (o_calc_cmd),
        .o_logic_error (o_logic_error),
        .o_led         (o_led)
    );

endmodule

`default_nettype wire

// File: verif/tb_matrix_ctrl.sv
`default_nettype none

module tb_matrix_ctrl;

    import mat_pkg::*;

    localparam int DRV_DLY = 5;    // drive and sample point after posedge
    localparam int TIMEOUT = 200;  // cycles per wait

    localparam int W_LED   = 0;
    localparam int W_ADDR  = 1;
    localparam int W_QUERY = 2;
    localparam int W_DIM   = 3;
    localparam int W_ID    = 4;
    localparam int W_CALC  = 5;

    logic        clk;
    logic        rst_n;
    logic [2:0]  btn;
    logic [7:0]  sw;
    logic        dims_valid;
    shape_t      dim;
    logic        rx_done;
    logic        error_flag;
    logic [1:0]  id;
    logic        id_valid;
    logic        calc_done;
    logic        en_input;
    input_task_t input_task;
    logic        addr_ready;
    logic [8:0]  base_addr;
    logic        start_calc;
    calc_cmd_t   calc_cmd;
    logic        logic_error;
    logic [7:0]  led;
    logic [4:0]  types_count;
    logic [7:0]  total_count;

    // ledger counts expected after the last finished step
    int          exp_types_now;
    int          exp_total_now;
    logic        abort_pending;
    shape_t      abort_shape;
    logic [8:0]  abort_addr;

    matrix_ctrl #(
        .MAX_TYPES       (25),
        .DEBOUNCE_CYCLES (4)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_btn         (btn),
        .i_sw          (sw),
        .i_dims_valid  (dims_valid),
        .i_dim         (dim),
        .i_rx_done     (rx_done),
        .i_error_flag  (error_flag),
        .i_id          (id),
        .i_id_valid    (id_valid),
        .i_calc_done   (calc_done),
        .o_en_input    (en_input),
        .o_input_task  (input_task),
        .o_addr_ready  (addr_ready),
        .o_base_addr   (base_addr),
        .o_start_calc  (start_calc),
        .o_calc_cmd    (calc_cmd),
        .o_logic_error (logic_error),
        .o_led         (led),
        .o_types_count (types_count),
        .o_total_count (total_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ============================================================
    // helpers
    // ============================================================
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRV_DLY;
        end
    endtask

    task automatic wait_for(input int kind, input logic [7:0] want, input string what);
        int  n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (!hit) begin
            case (kind)
                W_LED:   hit = (led == want);
                W_ADDR:  hit = addr_ready;
                W_QUERY: hit = en_input && input_task == TASK_QUERY;
                W_DIM:   hit = input_task == TASK_INDEX || logic_error;
                W_ID:    hit = input_task == TASK_QUERY || !en_input || logic_error;
                default: hit = start_calc || logic_error;
            endcase
            if (!hit) begin
                n++;
                if (n > TIMEOUT)
                    fail_now({"Timeout while waiting for ", what});
                step(1);
            end
        end
    endtask

    task automatic press(input int b);
        btn[b] = 1'b1;
        step(10);
        btn[b] = 1'b0;
        step(10);  // let the filter settle low
    endtask

    task automatic go_idle();
        press(2);
        wait_for(W_LED, 8'h01, "idle LED after menu");
        check("o_en_input", en_input, 0);
    endtask

    task automatic enter_mode(input logic [1:0] mode, input logic [7:0] mode_led);
        sw = {6'b0, mode};
        press(0);
        wait_for(W_LED, mode_led, "mode LED");
    endtask

    function automatic shape_t result_shape(input op_t op, input shape_t a, input shape_t b);
        shape_t r;
        case (op)
            OP_TRANSPOSE: r = '{m: a.n, n: a.m};
            OP_MATMUL:    r = '{m: a.m, n: b.n};
            default:      r = a;
        endcase
        return r;
    endfunction

    // ============================================================
    // scenario steps
    // ============================================================
    task automatic store_matrix(input shape_t s, input int exp_addr, input int exp_types,
                                input int exp_total);
        enter_mode(2'b00, 8'h02);
        check("o_en_input", en_input, 1);
        check("o_input_task", input_task, TASK_STORE);
        dim        = s;
        dims_valid = 1'b1;
        step(1);
        dims_valid = 1'b0;
        wait_for(W_ADDR, 8'h00, "o_addr_ready");
        check("o_base_addr", base_addr, exp_addr);
        if (abort_pending && s == abort_shape) begin
            check("o_base_addr", abort_addr, exp_addr);  // aborted store had this slot
            abort_pending = 1'b0;
        end
        rx_done = 1'b1;
        step(1);
        rx_done = 1'b0;
        check("o_addr_ready", addr_ready, 0);
        wait_for(W_LED, 8'h80, "wait state LED");
        go_idle();
        check("o_types_count", types_count, exp_types);
        check("o_total_count", total_count, exp_total);
        exp_types_now = exp_types;
        exp_total_now = exp_total;
    endtask

    task automatic abort_store(input shape_t s);
        enter_mode(2'b00, 8'h02);
        dim        = s;
        dims_valid = 1'b1;
        step(1);
        dims_valid = 1'b0;
        wait_for(W_ADDR, 8'h00, "o_addr_ready");
        abort_shape   = s;
        abort_addr    = base_addr;
        abort_pending = 1'b1;
        error_flag    = 1'b1;
        step(1);
        error_flag = 1'b0;
        wait_for(W_LED, 8'hFF, "error LED");
        go_idle();
        check("o_types_count", types_count, exp_types_now);
        check("o_total_count", total_count, exp_total_now);
    endtask

    task automatic get_operand(input shape_t s, input int idx, output logic err);
        dim        = s;
        dims_valid = 1'b1;
        step(1);
        dims_valid = 1'b0;
        wait_for(W_DIM, 8'h00, "index request");
        err = logic_error;
        if (!err) begin
            id       = idx[1:0];
            id_valid = 1'b1;
            step(1);
            id_valid = 1'b0;
            wait_for(W_ID, 8'h00, "index accept");
            err = logic_error;
        end
    endtask

    task automatic request_calc(input op_t op, input shape_t s1, input int id1,
                                input shape_t s2, input int id2, input int scalar,
                                input int exp_legal, input int a1, input int a2,
                                input int res_addr);
        logic   err;
        shape_t res;
        enter_mode(2'b10, 8'h08);
        sw = {op, 5'b0};
        press(0);
        wait_for(W_QUERY, 8'h00, "shape request");
        get_operand(s1, id1, err);
        if (!err && (op == OP_ADD || op == OP_MATMUL))
            get_operand(s2, id2, err);
        if (!err && op == OP_SCALE) begin
            sw = {scalar[3:0], 4'h0};
            wait_for(W_LED, {4'h0, scalar[3:0]}, "scalar LED");
            btn[0] = 1'b1;  // released after the command
        end
        if (!err) begin
            wait_for(W_CALC, 8'h00, "o_start_calc");
            err = logic_error;
        end
        check("o_logic_error", err, exp_legal == 0);
        if (err) begin
            check("o_led", led, 8'hFF);
        end else begin
            res = result_shape(op, s1, s2);
            check("o_calc_cmd.op", calc_cmd.op, op);
            check("o_calc_cmd.op1.addr", calc_cmd.op1.addr, a1);
            check("o_calc_cmd.op1.shape", calc_cmd.op1.shape, s1);
            check("o_calc_cmd.op2.addr", calc_cmd.op2.addr, a2);
            check("o_calc_cmd.op2.shape", calc_cmd.op2.shape, s2);
            check("o_calc_cmd.scalar", calc_cmd.scalar, scalar);
            check("o_calc_cmd.res.shape", calc_cmd.res.shape, res);
            check("o_calc_cmd.res.addr", calc_cmd.res.addr, res_addr);
            calc_done = 1'b1;  // arithmetic core finished
            step(1);
            calc_done = 1'b0;
            check("o_start_calc", start_calc, 0);
            wait_for(W_LED, 8'h80, "wait state LED");
        end
        btn[0] = 1'b0;
        step(10);
        go_idle();
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        int                fd;
        int                code;
        int                f[12];
        logic [8*8-1:0]    kw;
        logic [8*256-1:0]  line;
        btn           = '0;
        sw            = '0;
        dims_valid    = 1'b0;
        dim           = '0;
        rx_done       = 1'b0;
        error_flag    = 1'b0;
        id            = '0;
        id_valid      = 1'b0;
        calc_done     = 1'b0;
        exp_types_now = 0;
        exp_total_now = 0;
        abort_pending = 1'b0;
        abort_shape   = '0;
        abort_addr    = '0;
        rst_n         = 1'b0;
        repeat (4) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;
        step(1);
        check("o_led", led, 8'h01);
        check("o_types_count", types_count, 0);
        check("o_total_count", total_count, 0);
        check("o_en_input", en_input, 0);
        check("o_addr_ready", addr_ready, 0);
        check("o_start_calc", start_calc, 0);
        check("o_logic_error", logic_error, 0);

        fd = $fopen("verif/stimulus_ops.txt", "r");
        if (fd == 0)
            fail_now("could not open the stimulus file");
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", kw);
            if (code != 1)
                break;
            if (kw == "#") begin
                code = $fgets(line, fd);  // comment line
            end else if (kw == "STORE") begin
                code = $fscanf(fd, "%d %d %d %d %d", f[0], f[1], f[2], f[3], f[4]);
                if (code != 5)
                    fail_now("malformed STORE line in the stimulus file");
                store_matrix({f[0][3:0], f[1][3:0]}, f[2], f[3], f[4]);
            end else if (kw == "ABORT") begin
                code = $fscanf(fd, "%d %d", f[0], f[1]);
                if (code != 2)
                    fail_now("malformed ABORT line in the stimulus file");
                abort_store({f[0][3:0], f[1][3:0]});
            end else if (kw == "CALC") begin
                code = $fscanf(fd, "%d %h %d %h %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
                               f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
                if (code != 12)
                    fail_now("malformed CALC line in the stimulus file");
                request_calc(op_t'(f[0][2:0]), f[1][7:0], f[2], f[3][7:0], f[4], f[5], f[6],
                             f[7], f[8], f[9]);
                check("o_types_count", types_count, f[10]);
                check("o_total_count", total_count, f[11]);
                exp_types_now = f[10];
                exp_total_now = f[11];
            end else if (kw == "MENU") begin
                enter_mode(2'b10, 8'h08);
                sw = {OP_MATMUL, 5'b0};
                press(0);
                wait_for(W_QUERY, 8'h00, "shape request");
                go_idle();
            end else begin
                fail_now("unknown keyword in the stimulus file");
            end
        end
        $fclose(fd);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/stimulus_ops.txt
# STORE m n exp_addr exp_types exp_total | ABORT m n | MENU   (decimal fields)
# CALC op shape1(hex mn) id1 shape2(hex mn) id2 scalar exp_legal exp_a1 exp_a2 exp_res exp_types exp_total
STORE 2 3 0 1 1
STORE 2 3 6 1 2
STORE 2 3 0 1 2
STORE 3 2 12 2 3
ABORT 3 2
STORE 3 2 18 2 4
ABORT 4 4
STORE 4 4 24 3 5
# legal commands
CALC 0 23 2 00 0 0 1 6 0 12 3 5
CALC 3 23 1 32 2 0 1 0 18 56 4 6
CALC 2 44 1 00 0 7 1 24 0 40 4 7
CALC 1 23 1 23 2 0 1 0 6 6 4 7
# shape mismatch, index out of range, shape not stored
CALC 1 23 1 32 1 0 0 0 0 0 4 7
CALC 0 22 2 00 0 0 0 0 0 0 4 7
CALC 0 23 0 00 0 0 0 0 0 0 4 7
CALC 0 55 1 00 0 0 0 0 0 0 4 7
MENU
STORE 2 2 60 4 8

// File: flist.f
design/mat_pkg.sv
design/btn_edge.sv
design/shape_ledger.sv
design/calc_sequencer.sv
design/matrix_ctrl.sv
verif/tb_matrix_ctrl.sv

// File: run.sh
#!/bin/sh
# compile and run the matrix controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_matrix_ctrl \
    -f flist.f \
    -o sim_matrix_ctrl

./obj_dir/sim_matrix_ctrl 2>&1 | tee sim.log

if grep -q "TEST OK" sim.log; then
    exit 0
fi
exit 1
